// File: frontEnd.f
hdl/frontEndPkg.sv
hdl/instFetch.sv
hdl/instBuffer.sv
hdl/frontEnd.sv
sim/frontEnd_chk.sv
sim/frontEnd_tb.sv

// File: sim/frontEnd_tests.txt
// header: nMem nRec irqOn irqOff brPc brTarget intrWord intrImm
// memory image at 10, records at 30 as pc immVal isBranch
00000014 0000000F 00000010 00000005 00000018 00000030 B9DC0010 00000010
@10
00221800 2060FFFE B0001234 20808765
00A63C00 A0C600FF B8000030 00221800
00221800 00221800 00221800 00221800
20E07FFF B000FFFF 21000001 00A63C00
A0C600FF 00221800 2060FFFE 00A63C00
@30
00000000 00001800 0
00000004 FFFFFFFE 0
00000008 00001234 0
0000000C 12348765 0
00000010 00003C00 0
00000014 000000FF 0
00000018 00000030 1
00000030 00007FFF 0
00000034 FFFFFFFF 0
00000038 FFFF0001 0
0000003C 00003C00 0
00000040 000000FF 0
00000044 00001800 0
00000048 FFFFFFFE 0
0000004C 00003C00 0

// File: sim/frontEnd_tb.sv
`timescale 1ns/100ps
`default_nettype none

module frontEnd_tb;

  logic gclk;
  logic reset;
  logic arready;
  logic rvalid;
  logic [31:0] rdata;
  logic irq;
  logic intEnable;
  logic branchTaken;
  logic [frontEndPkg::addrWidth-1:0] branchTarget;
  logic execReady;
  logic [frontEndPkg::addrWidth-1:0] araddr;
  logic arvalid;
  logic rready;
  frontEndPkg::execStage_t execStage;

  // header, memory image at 16, records at 48
  logic [31:0] tv [0:127];
  int cycle = 0;
  int recIdx = 0;
  int intrCount = 0;
  int fieldErrors = 0;
  int addrErrors = 0;
  int otherErrors = 0;
  logic [31:0] expAddr = 0;
  logic expectTarget = 0;
  logic staleSeen = 0;
  logic brSeen = 0;
  logic lastImm = 0;
  logic lastBranch = 0;
  logic lastTaken = 0;
  int seedVal;

  frontEnd dut_i (.*);

  initial begin
    gclk = 1'b0;
    forever #4 gclk = ~gclk;
  end

  // word at a byte address, fill pattern outside the image
  function automatic logic [31:0] memWord(input logic [31:0] addr);
    if (addr[31:2] < tv[0])
      return tv[16 + addr[31:2]];
    return {6'h20, addr[27:2] ^ {22'h0, addr[31:28]}};
  endfunction

  // fields straight from the instruction bits
  function automatic frontEndPkg::execStage_t expectRecord(input logic [31:0] pc, word,
      imm, input logic br, intr);
    return '{valid: 1'b1, pc: pc, opc: word[31:26], rd: word[25:21], ra: word[20:16],
             rb: word[15:11], alt: word[10:0], immVal: imm, isBranch: br, isIntr: intr};
  endfunction

  task automatic compareField(input string name, input logic [31:0] got, exp);
    if (got !== exp) begin
      fieldErrors++;
      $display("[ERROR] %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkExec(input frontEndPkg::execStage_t got, exp);
    compareField("pc", got.pc, exp.pc);
    compareField("opc", got.opc, exp.opc);
    compareField("rd", got.rd, exp.rd);
    compareField("ra", got.ra, exp.ra);
    compareField("rb", got.rb, exp.rb);
    compareField("alt", got.alt, exp.alt);
    compareField("immVal", got.immVal, exp.immVal);
    compareField("isBranch", got.isBranch, exp.isBranch);
    compareField("isIntr", got.isIntr, exp.isIntr);
  endtask

  // sequential addresses, one stale read allowed across the redirect
  task automatic checkAddr(input logic [frontEndPkg::addrWidth-1:0] got);
    if (expectTarget && got == tv[5]) begin
      expectTarget = 1'b0;
      expAddr = got + 32'd4;
    end else if (expectTarget && got == expAddr && !staleSeen) begin
      staleSeen = 1'b1;
    end else if (got != expAddr || expectTarget) begin
      addrErrors++;
      $display("[ERROR] %0t: araddr got %h expected %h", $time, got, expAddr);
      expAddr = got + 32'd4;
    end else begin
      expAddr = got + 32'd4;
    end
  endtask

  task automatic scoreRecord(input frontEndPkg::execStage_t got);
    logic [31:0] pc;
    pc = tv[48 + 3 * recIdx];
    if (got.isIntr) begin
      intrCount++;
      // resumes at the next undelivered pc
      checkExec(got, expectRecord(pc, tv[6], tv[7], 1'b1, 1'b1));
      // two sync stages and the latch come first
      if (lastImm || (lastBranch && !lastTaken) || cycle < tv[2] + 4) begin
        otherErrors++;
        $display("interrupt injected in a forbidden slot at time %0t", $time);
      end
    end else if (recIdx < tv[1]) begin
      checkExec(got, expectRecord(pc, memWord(pc), tv[49 + 3 * recIdx],
                                  tv[50 + 3 * recIdx][0], 1'b0));
      recIdx++;
    end
    lastImm = got.opc == 6'o54;
    lastBranch = got.isBranch;
    lastTaken = !got.isIntr && got.pc == tv[4];
  endtask

  // AXI4-Lite read slave with random ar and r waits
  initial begin : axiMemory
    logic arHs;
    logic rHs;
    logic [31:0] hsAddr;
    int arDelay;
    int rDelay;
    logic respPending;
    arDelay = 0;
    rDelay = 0;
    respPending = 1'b0;
    wait (!reset);
    forever begin
      @(negedge gclk);
      arHs = arvalid && arready;
      rHs = rvalid && rready;
      hsAddr = araddr;
      @(posedge gclk);
      #1;
      if (rHs)
        rvalid = 1'b0;
      if (arHs) begin
        arready = 1'b0;
        arDelay = $urandom_range(3);
        rDelay = $urandom_range(3);
        respPending = 1'b1;
      end else if (arvalid && !arready) begin
        if (arDelay == 0)
          arready = 1'b1;
        else
          arDelay--;
      end
      if (respPending && !rvalid) begin
        if (rDelay == 0) begin
          rvalid = 1'b1;
          rdata = memWord(hsAddr);
          respPending = 1'b0;
        end else begin
          rDelay--;
        end
      end
    end
  end

  // execute-stage model, irq pulses and the enable window
  initial begin : execDriver
    wait (!reset);
    forever begin
      @(posedge gclk);
      #1;
      cycle++;
      irq = (cycle == tv[2]) || (cycle == tv[3]);
      intEnable = !(cycle + 1 >= tv[3] && cycle <= tv[3] + 6);
      if (execStage.valid && !execStage.isIntr && execStage.pc == tv[4] && !brSeen) begin
        branchTaken = 1'b1;
        branchTarget = tv[5];
        execReady = 1'b1;
        brSeen = 1'b1;
      end else begin
        branchTaken = 1'b0;
        execReady = $urandom_range(3) != 0;
      end
    end
  end

  // sample between edges, inputs and outputs both settled
  initial begin : monitor
    wait (!reset);
    forever begin
      @(negedge gclk);
      if (arvalid && arready)
        checkAddr(araddr);
      // a response only comes for an accepted read
      if (rvalid && !rready) begin
        otherErrors++;
        $display("[ERROR] %0t: rready low while rvalid is high", $time);
      end
      if (branchTaken)
        expectTarget = 1'b1;
      if (execStage.valid && execReady)
        scoreRecord(execStage);
    end
  end

  initial begin : watchdog
    #1;
    repeat (tv[1] * 40 + 200) @(posedge gclk);
    $display("timeout: not all expected records reached the execute stage");
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    seedVal = $urandom(32'h83cfad4b);
    $readmemh("sim/frontEnd_tests.txt", tv);
    reset = 1'b1;
    arready = 1'b0;
    rvalid = 1'b0;
    rdata = '0;
    irq = 1'b0;
    intEnable = 1'b1;
    branchTaken = 1'b0;
    branchTarget = '0;
    execReady = 1'b0;
    repeat (3) @(posedge gclk);
    #1;
    reset = 1'b0;
    wait (recIdx == tv[1]);
    repeat (4) @(posedge gclk);
    // only the enabled pulse may be taken
    if (intrCount != 1) begin
      otherErrors++;
      $display("expected one interrupt injection but saw %0d", intrCount);
    end
    $display("errors: field %0d, address %0d, other %0d", fieldErrors, addrErrors,
             otherErrors);
    if (fieldErrors + addrErrors + otherErrors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/frontEnd_chk.sv
`timescale 1ns/100ps
`default_nettype none

module frontEnd_chk (
  input logic gclk,
  input logic reset,
  input logic arvalid,
  input logic arready,
  input logic [frontEndPkg::addrWidth-1:0] araddr,
  input logic inject,
  input logic xValid,
  input logic xBranch,
  input frontEndPkg::fetchWord_t dWord
);

  // ar channel holds until accepted
  assert property (@(posedge gclk) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else $error("arvalid or araddr changed before arready");

  // no injection while a live branch sits in x
  assert property (@(posedge gclk) disable iff (reset)
    inject |-> !(xValid && xBranch))
    else $error("inject while a branch sits in the execute stage");

  // held word stays in decode across the injection
  assert property (@(posedge gclk) disable iff (reset)
    inject |=> $stable(dWord))
    else $error("held word changed after an injection");

endmodule

bind frontEnd frontEnd_chk chk_i (
  .gclk(gclk),
  .reset(reset),
  .arvalid(arvalid),
  .arready(arready),
  .araddr(araddr),
  .inject(inject),
  .xValid(execStage.valid),
  .xBranch(execStage.isBranch),
  .dWord(dWord)
);

`default_nettype wire

// File: hdl/frontEnd.sv
`timescale 1ns/100ps
`default_nettype none

module frontEnd (
  input  logic gclk,
  input  logic reset,
  input  logic arready,
  input  logic rvalid,
  input  logic [31:0] rdata,
  input  logic irq,
  input  logic intEnable,
  input  logic branchTaken,
  input  logic [frontEndPkg::addrWidth-1:0] branchTarget,
  input  logic execReady,
  output logic [frontEndPkg::addrWidth-1:0] araddr,
  output logic arvalid,
  output logic rready,
  output frontEndPkg::execStage_t execStage
);

  // decode-stage word from fetch
  frontEndPkg::fetchWord_t dWord;
  logic consume;
  // not used by fetch, held word simply stays
  logic inject;

  // pc and axi read master
  instFetch fetch_i (
    .gclk(gclk),
    .reset(reset),
    .consume(consume),
    .branchTaken(branchTaken),
    .branchTarget(branchTarget),
    .arready(arready),
    .rvalid(rvalid),
    .rdata(rdata),
    .araddr(araddr),
    .arvalid(arvalid),
    .rready(rready),
    .dWord(dWord)
  );

  // decode, interrupt injection, x register
  instBuffer buffer_i (
    .gclk(gclk),
    .reset(reset),
    .dWord(dWord),
    .irq(irq),
    .intEnable(intEnable),
    .branchTaken(branchTaken),
    .execReady(execReady),
    .consume(consume),
    .inject(inject),
    .execStage(execStage)
  );

endmodule

`default_nettype wire

// File: hdl/instBuffer.sv
`timescale 1ns/100ps
`default_nettype none

module instBuffer (
  input  logic gclk,
  input  logic reset,
  input  frontEndPkg::fetchWord_t dWord,
  input  logic irq,
  input  logic intEnable,
  input  logic branchTaken,
  input  logic execReady,
  output logic consume,
  output logic inject,
  output frontEndPkg::execStage_t execStage
);

  // rtd, bru/brui and bcc/bcci families
  function automatic logic isBranchOp(input logic [5:0] opc);
    return (opc == frontEndPkg::opRtd) ||
           (opc == frontEndPkg::opBru) ||
           (opc == frontEndPkg::opBrui) ||
           (opc == frontEndPkg::opBcc) ||
           (opc == frontEndPkg::opBcci);
  endfunction

  frontEndPkg::instWord_u selWord;
  // irq double flop
  logic [1:0] irqSync;
  logic intLatch;
  // injected word not yet retired from x
  logic intPending;
  // first word after a taken branch
  logic redirected;
  logic dBranch;
  logic dImm;
  logic xBranch;
  logic xImm;
  logic safeSlot;
  logic advance;
  logic intLeave;
  logic [31:0] immVal;

  // classify the fetched word, not the selected one
  assign dBranch = isBranchOp(dWord.word.typeA.opc);
  assign dImm = dWord.word.typeB.opc == frontEndPkg::opImm;
  // x fields persist after valid drops, so delay slot stays guarded
  assign xBranch = execStage.isBranch;
  assign xImm = execStage.opc == frontEndPkg::opImm;

  assign advance = dWord.valid && execReady && !branchTaken;

  // never split an imm pair or sit behind a branch
  // a redirect makes the next slot safe again
  assign safeSlot = redirected || (!dBranch && !xBranch && !dImm && !xImm);

  assign inject = advance && intLatch && !intPending && safeSlot;
  // held word stays in place while the interrupt goes out
  assign consume = advance && !inject;

  assign selWord = inject ? frontEndPkg::intOpWord : dWord.word;

  // imm prefix supplies the upper half
  assign immVal = xImm ?
                  {execStage.immVal[15:0], selWord.typeB.imm} :
                  {{16{selWord.typeB.imm[15]}}, selWord.typeB.imm};

  // injected word handed on or flushed
  assign intLeave = execStage.valid && execStage.isIntr && (execReady || branchTaken);

  always_ff @(posedge gclk) begin
    if (reset) begin
      irqSync <= '0;
      intLatch <= 1'b0;
      intPending <= 1'b0;
      redirected <= 1'b0;
      execStage <= '0;
    end else begin
      irqSync <= {irqSync[0], irq};

      // level latch, dropped when interrupts are masked
      if (intLeave || !intEnable) begin
        intLatch <= 1'b0;
      end else if (irqSync[1]) begin
        intLatch <= 1'b1;
      end

      if (intLeave) begin
        intPending <= 1'b0;
      end else if (inject) begin
        intPending <= 1'b1;
      end

      if (branchTaken) begin
        redirected <= 1'b1;
      end else if (advance) begin
        redirected <= 1'b0;
      end

      // x register, held while execute stalls
      if (branchTaken) begin
        execStage.valid <= 1'b0;
      end else if (advance) begin
        // return pc is the held word's own pc
        execStage <= '{
          valid: 1'b1,
          pc: dWord.pc,
          opc: selWord.typeA.opc,
          rd: selWord.typeA.rd,
          ra: selWord.typeA.ra,
          rb: selWord.typeA.rb,
          alt: selWord.typeA.alt,
          immVal: immVal,
          isBranch: isBranchOp(selWord.typeA.opc),
          isIntr: inject
        };
      end else if (execReady) begin
        execStage.valid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/instFetch.sv
`timescale 1ns/100ps
`default_nettype none

module instFetch (
  input  logic gclk,
  input  logic reset,
  input  logic consume,
  input  logic branchTaken,
  input  logic [frontEndPkg::addrWidth-1:0] branchTarget,
  input  logic arready,
  input  logic rvalid,
  input  logic [31:0] rdata,
  output logic [frontEndPkg::addrWidth-1:0] araddr,
  output logic arvalid,
  output logic rready,
  output frontEndPkg::fetchWord_t dWord
);

  // next address to request
  logic [frontEndPkg::addrWidth-1:0] pc;
  // one read in flight between ar and r handshakes
  logic busy;
  // in-flight read was cancelled by a branch
  logic drop;
  logic heldValid;
  logic [frontEndPkg::addrWidth-1:0] heldPc;
  frontEndPkg::instWord_u heldWord;
  logic wordFree;
  logic startRead;
  logic [frontEndPkg::addrWidth-1:0] startAddr;
  logic arDone;
  logic rDone;

  // slot empties this cycle, or already empty
  assign wordFree = !heldValid || consume || branchTaken;
  // only one read outstanding at a time
  assign startRead = wordFree && !arvalid && !busy;
  // a redirect in the same cycle goes straight out
  assign startAddr = branchTaken ? branchTarget : pc;

  assign arDone = arvalid && arready;
  assign rDone = busy && rvalid;
  // always ready for the response we asked for
  assign rready = busy;

  assign dWord = '{valid: heldValid, pc: heldPc, word: heldWord};

  always_ff @(posedge gclk) begin
    if (reset) begin
      pc <= '0;
      arvalid <= 1'b0;
      busy <= 1'b0;
      drop <= 1'b0;
      heldValid <= 1'b0;
    end else begin
      // pc runs one word ahead of the issued address
      if (startRead) begin
        pc <= startAddr + 32'd4;
      end else if (branchTaken) begin
        pc <= branchTarget;
      end

      // address phase
      if (startRead) begin
        arvalid <= 1'b1;
      end else if (arDone) begin
        arvalid <= 1'b0;
      end

      // data phase
      if (arDone) begin
        busy <= 1'b1;
      end else if (rDone) begin
        busy <= 1'b0;
      end

      // stale read still pending, drain it later
      if (branchTaken && (arvalid || (busy && !rvalid))) begin
        drop <= 1'b1;
      end else if (rDone) begin
        drop <= 1'b0;
      end

      // hold the word until decode takes it
      if (rDone && !drop && !branchTaken) begin
        heldValid <= 1'b1;
      end else if (consume || branchTaken) begin
        heldValid <= 1'b0;
      end
    end
  end

  // address and payload, no reset needed
  always_ff @(posedge gclk) begin
    if (startRead) begin
      araddr <= startAddr;
    end
    // araddr still names the outstanding read
    if (rDone) begin
      heldPc <= araddr;
      heldWord <= rdata;
    end
  end

endmodule

`default_nettype wire

// File: hdl/frontEndPkg.sv
`default_nettype none

package frontEndPkg;

  // fetch address width
  localparam int addrWidth = 32;

  // interrupt handler entry
  localparam logic [addrWidth-1:0] intVector = 32'h0000_0010;

  // major opcodes used for imm merge and branch classes
  localparam logic [5:0] opImm = 6'o54;
  localparam logic [5:0] opRtd = 6'o55;
  localparam logic [5:0] opBru = 6'o46;
  localparam logic [5:0] opBrui = 6'o56;
  localparam logic [5:0] opBcc = 6'o47;
  localparam logic [5:0] opBcci = 6'o57;

  // bralid r14, intVector
  // ra field 5'h1c sets the delay, absolute and link flags
  localparam logic [31:0] intOpWord = {opBrui, 5'd14, 5'h1c, intVector[15:0]};

  // register-register layout
  typedef struct packed {
    logic [5:0] opc;
    logic [4:0] rd;
    logic [4:0] ra;
    logic [4:0] rb;
    logic [10:0] alt;
  } typeA_t;

  // register-immediate layout
  typedef struct packed {
    logic [5:0] opc;
    logic [4:0] rd;
    logic [4:0] ra;
    logic [15:0] imm;
  } typeB_t;

  // same word, both decodings
  typedef union packed {
    typeA_t typeA;
    typeB_t typeB;
  } instWord_u;

  // word held in decode
  typedef struct packed {
    logic valid;
    logic [addrWidth-1:0] pc;
    instWord_u word;
  } fetchWord_t;

  // execute-stage register contents
  typedef struct packed {
    logic valid;
    logic [addrWidth-1:0] pc;
    logic [5:0] opc;
    logic [4:0] rd;
    logic [4:0] ra;
    logic [4:0] rb;
    logic [10:0] alt;
    logic [31:0] immVal;
    logic isBranch;
    logic isIntr;
  } execStage_t;

endpackage

`default_nettype wire
